// ==== Makefile ====
# Verilator simulation of the SPI host testbench

LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f project.f --top-module tb_spi_host -Mdir obj_dir
	-./obj_dir/Vtb_spi_host > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TB FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "TB PASSED" $(LOG) || { echo "Simulation ended without a result"; exit 1; }

clean:
	rm -rf obj_dir $(LOG)

// ==== common/axil_pkg.sv ====
/*
 * AXI4-Lite types shared by the bus front end, the read collector and the top.
 * Only OKAY and SLVERR are ever returned; EXOKAY and DECERR are not used.
 */
`include "spi_cfg.svh"

package axil_pkg;

  // Byte address on the slave port
  typedef logic [`AXIL_ADDR_W-1:0] axil_addr_t;

  // Data word and its byte strobe
  typedef logic [31:0] axil_data_t;
  typedef logic [3:0]  axil_strb_t;

  // Response code on the B and R channels
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10  // Address outside the channels or an unknown register
  } axil_resp_e;

endpackage

// ==== common/spi_cfg.svh ====
/*
 * Build-time configuration of the SPI host controller.
 * Address layout assumes a 16-byte window per channel, and at most 16 channels fit in 8 bits.
 * The divider width must be a multiple of 8 so that byte strobes cover it.
 */
`ifndef SPI_CFG_SVH
`define SPI_CFG_SVH

// ==============================
// Channel layout
// ==============================
`define SPI_NUM_CH    4       // Number of generated SPI engines
`define SPI_CH_STRIDE 16      // Bytes of address space per channel

// ==============================
// Engine timing
// ==============================
`define SPI_DIV_W     16      // Width of the clock divider register
`define SPI_CPOL      1'b0    // Idle level of sclk

// ==============================
// Bus
// ==============================
`define AXIL_ADDR_W   8

`endif

// ==== common/spi_pkg.sv ====
/*
 * Types that describe one SPI channel and its register map.
 * Register offsets assume a 16-byte channel stride.
 */
`include "spi_cfg.svh"

package spi_pkg;

  // A single channel still needs a one-bit index
  localparam int SPI_CH_W = (`SPI_NUM_CH > 1) ? $clog2(`SPI_NUM_CH) : 1;

  typedef logic [SPI_CH_W-1:0]   spi_ch_t;
  typedef logic [7:0]            spi_byte_t;
  typedef logic [`SPI_DIV_W-1:0] spi_div_t;

  // ==============================
  // Register offsets within a channel
  // ==============================
  typedef enum logic [3:0] {
    CTRL = 4'h0,  // Chip select and mode
    DATA = 4'h4,  // Transmit on write, last received byte on read
    DIV  = 4'h8   // Half period of sclk in clock cycles
  } spi_reg_e;

  // ==============================
  // Shift engine state
  // ==============================
  typedef enum logic [1:0] {
    IDLE,
    SHIFT,  // Bits still to be clocked out
    DONE    // Last sample taken, waiting for the final trailing edge
  } spi_state_e;

endpackage

// ==== project.f ====
+incdir+common
common/axil_pkg.sv
common/spi_pkg.sv
source/spi_bus_slave.sv
spi_engine/spi_engine.sv
source/spi_read_collect.sv
source/spi_host_top.sv
tests/spi_device_model.sv
tests/tb_spi_host.sv

// ==== source/spi_bus_slave.sv ====
/*
 * AXI4-Lite front end with a single transaction in flight.
 * AxPROT is not a port. Unaligned byte offsets are rounded down to a word.
 * Writes win over reads that arrive on the same cycle.
 */
`timescale 1ns/1ps
`include "spi_cfg.svh"

module spi_bus_slave import axil_pkg::*, spi_pkg::*; (
  input  logic                   clk,
  input  logic                   resetn,
  // AXI4-Lite slave
  input  logic                   s_awvalid,
  output logic                   s_awready,
  input  axil_addr_t             s_awaddr,
  input  logic                   s_wvalid,
  output logic                   s_wready,
  input  axil_data_t             s_wdata,
  input  axil_strb_t             s_wstrb,
  output logic                   s_bvalid,
  input  logic                   s_bready,
  output axil_resp_e             s_bresp,
  input  logic                   s_arvalid,
  output logic                   s_arready,
  input  axil_addr_t             s_araddr,
  // Engine requests
  output logic [`SPI_NUM_CH-1:0] req_valid,
  output spi_reg_e               req_reg,
  output logic                   req_write,
  output axil_data_t             req_wdata,
  output axil_strb_t             req_wstrb,
  input  logic [`SPI_NUM_CH-1:0] req_ready,
  // Read collector
  output spi_ch_t                rd_ch,
  output logic                   rd_take,
  output logic                   rd_err,
  input  logic                   rd_busy
);

  localparam int OFF_W      = $clog2(`SPI_CH_STRIDE);
  localparam int CH_FIELD_W = `AXIL_ADDR_W - OFF_W;

  typedef enum logic [1:0] {
    B_IDLE,
    B_WAIT,  // Request raised, waiting for the engine
    B_RESP   // bvalid held, or the read take pulse
  } bus_state_e;

  bus_state_e            state_q;
  logic                  err_q;
  logic                  wr_go;
  logic                  rd_go;
  axil_addr_t            dec_addr;
  logic [CH_FIELD_W-1:0] dec_ch;
  logic [OFF_W-1:0]      dec_off;
  logic                  dec_err;

  // ==============================
  // Accept and decode
  // ==============================
  // A read response still held in the collector blocks everything new
  assign wr_go = (state_q == B_IDLE) && !rd_busy && s_awvalid && s_wvalid;
  assign rd_go = (state_q == B_IDLE) && !rd_busy && s_arvalid && !(s_awvalid && s_wvalid);

  assign s_awready = wr_go;
  assign s_wready  = wr_go;
  assign s_arready = rd_go;

  assign dec_addr = wr_go ? s_awaddr : s_araddr;
  assign dec_ch   = dec_addr[`AXIL_ADDR_W-1:OFF_W];
  assign dec_off  = {dec_addr[OFF_W-1:2], 2'b00};
  assign dec_err  = (dec_ch >= `SPI_NUM_CH) || !(dec_off inside {CTRL, DATA, DIV});

  assign s_bresp = err_q ? SLVERR : OKAY;
  assign rd_err  = err_q;

  // ==============================
  // Transaction sequencing
  // ==============================
  always_ff @(posedge clk) begin
    if (!resetn) begin
      state_q   <= B_IDLE;
      req_valid <= '0;
      req_write <= 1'b0;
      err_q     <= 1'b0;
      s_bvalid  <= 1'b0;
      rd_take   <= 1'b0;
    end else begin
      rd_take <= 1'b0;
      case (state_q)
        B_IDLE: begin
          if (wr_go || rd_go) begin
            // A bad address never reaches an engine
            req_valid <= dec_err ? '0 : (`SPI_NUM_CH'(1) << dec_ch);
            req_write <= wr_go;
            err_q     <= dec_err;
            state_q   <= B_WAIT;
          end
        end
        B_WAIT: begin
          if (err_q || |(req_valid & req_ready)) begin
            req_valid <= '0;                // Engine answered, drop the request
            if (req_write) begin
              s_bvalid <= 1'b1;
            end else begin
              rd_take <= 1'b1;
            end
            state_q <= B_RESP;
          end
        end
        B_RESP: begin
          if (!req_write) begin
            state_q <= B_IDLE;              // Collector now holds the R channel
          end else if (s_bready) begin
            s_bvalid <= 1'b0;
            state_q  <= B_IDLE;
          end
        end
        default: state_q <= B_IDLE;
      endcase
    end
  end

  // Request payload, captured with the address handshake
  always_ff @(posedge clk) begin
    if (wr_go || rd_go) begin
      req_reg   <= spi_reg_e'(dec_off);
      req_wdata <= s_wdata;
      req_wstrb <= s_wstrb;
      rd_ch     <= spi_ch_t'(dec_ch);
    end
  end

  // At most one engine is addressed at a time
  a_req_onehot: assert property (@(posedge clk) disable iff (!resetn)
    $onehot0(req_valid));

endmodule

// ==== source/spi_host_top.sv ====
/*
 * Multi-channel SPI host behind an AXI4-Lite slave port.
 * Pin vectors are indexed by channel; tristate pads are left to the board level.
 */
`timescale 1ns/1ps
`include "spi_cfg.svh"

module spi_host_top import axil_pkg::*, spi_pkg::*; (
  input  logic                        clk,
  input  logic                        resetn,
  // AXI4-Lite slave
  input  logic                        s_awvalid,
  output logic                        s_awready,
  input  axil_addr_t                  s_awaddr,
  input  logic                        s_wvalid,
  output logic                        s_wready,
  input  axil_data_t                  s_wdata,
  input  axil_strb_t                  s_wstrb,
  output logic                        s_bvalid,
  input  logic                        s_bready,
  output axil_resp_e                  s_bresp,
  input  logic                        s_arvalid,
  output logic                        s_arready,
  input  axil_addr_t                  s_araddr,
  output logic                        s_rvalid,
  input  logic                        s_rready,
  output axil_data_t                  s_rdata,
  output axil_resp_e                  s_rresp,
  // SPI pins per channel
  output logic [`SPI_NUM_CH-1:0]      sclk,
  output logic [`SPI_NUM_CH-1:0]      cen,
  output logic [`SPI_NUM_CH-1:0][3:0] sio_out,
  output logic [`SPI_NUM_CH-1:0][3:0] sio_oe,
  input  logic [`SPI_NUM_CH-1:0][3:0] sio_in
);

  logic [`SPI_NUM_CH-1:0] req_valid;
  logic [`SPI_NUM_CH-1:0] req_ready;
  spi_reg_e               req_reg;
  logic                   req_write;
  axil_data_t             req_wdata;
  axil_strb_t             req_wstrb;
  axil_data_t             eng_rdata [`SPI_NUM_CH];
  spi_ch_t                rd_ch;
  logic                   rd_take;
  logic                   rd_err;
  logic                   rd_busy;

  spi_bus_slave u_bus (
    .clk       (clk),
    .resetn    (resetn),
    .s_awvalid (s_awvalid),
    .s_awready (s_awready),
    .s_awaddr  (s_awaddr),
    .s_wvalid  (s_wvalid),
    .s_wready  (s_wready),
    .s_wdata   (s_wdata),
    .s_wstrb   (s_wstrb),
    .s_bvalid  (s_bvalid),
    .s_bready  (s_bready),
    .s_bresp   (s_bresp),
    .s_arvalid (s_arvalid),
    .s_arready (s_arready),
    .s_araddr  (s_araddr),
    .req_valid (req_valid),
    .req_reg   (req_reg),
    .req_write (req_write),
    .req_wdata (req_wdata),
    .req_wstrb (req_wstrb),
    .req_ready (req_ready),
    .rd_ch     (rd_ch),
    .rd_take   (rd_take),
    .rd_err    (rd_err),
    .rd_busy   (rd_busy)
  );

  // One engine per channel, all sharing the request payload
  for (genvar i = 0; i < `SPI_NUM_CH; i++) begin : g_eng
    spi_engine u_eng (
      .clk       (clk),
      .resetn    (resetn),
      .req_valid (req_valid[i]),
      .req_reg   (req_reg),
      .req_write (req_write),
      .req_wdata (req_wdata),
      .req_wstrb (req_wstrb),
      .req_ready (req_ready[i]),
      .rdata     (eng_rdata[i]),
      .sclk      (sclk[i]),
      .cen       (cen[i]),
      .sio_out   (sio_out[i]),
      .sio_oe    (sio_oe[i]),
      .sio_in    (sio_in[i])
    );
  end

  spi_read_collect u_rd (
    .clk      (clk),
    .resetn   (resetn),
    .ch_rdata (eng_rdata),
    .rd_ch    (rd_ch),
    .rd_take  (rd_take),
    .rd_err   (rd_err),
    .rd_busy  (rd_busy),
    .s_rvalid (s_rvalid),
    .s_rready (s_rready),
    .s_rdata  (s_rdata),
    .s_rresp  (s_rresp)
  );

endmodule

// ==== source/spi_read_collect.sv ====
/*
 * Holds one AXI4-Lite read response until rready.
 * Error responses carry zero data.
 */
`timescale 1ns/1ps
`include "spi_cfg.svh"

module spi_read_collect import axil_pkg::*, spi_pkg::*; (
  input  logic       clk,
  input  logic       resetn,
  input  axil_data_t ch_rdata [`SPI_NUM_CH],
  input  spi_ch_t    rd_ch,
  input  logic       rd_take,
  input  logic       rd_err,
  output logic       rd_busy,
  // AXI4-Lite read data channel
  output logic       s_rvalid,
  input  logic       s_rready,
  output axil_data_t s_rdata,
  output axil_resp_e s_rresp
);

  assign rd_busy = s_rvalid;  // Front end waits while a response is held

  always_ff @(posedge clk) begin
    if (!resetn) begin
      s_rvalid <= 1'b0;
    end else if (rd_take) begin
      s_rvalid <= 1'b1;
    end else if (s_rready) begin
      s_rvalid <= 1'b0;
    end
  end

  // Word and response code of the answering engine
  always_ff @(posedge clk) begin
    if (rd_take) begin
      s_rdata <= rd_err ? '0 : ch_rdata[rd_ch];
      s_rresp <= rd_err ? SLVERR : OKAY;
    end
  end

  a_rdata_hold: assert property (@(posedge clk) disable iff (!resetn)
    s_rvalid && !s_rready |=> s_rvalid && $stable(s_rdata));

  // The front end must not issue a new take while a response is pending
  a_no_overrun: assert property (@(posedge clk) disable iff (!resetn)
    rd_take |-> !s_rvalid);

endmodule

// ==== spi_engine/spi_engine.sv ====
/*
 * One SPI channel with CPHA 0, CPOL from the build config and one byte per transfer.
 * Pins are split into out, output enable and in; the pad is outside this block.
 * DATA accesses wait while a byte is shifting. CTRL and DIV are answered at once.
 */
`timescale 1ns/1ps
`include "spi_cfg.svh"

module spi_engine import axil_pkg::*, spi_pkg::*; (
  input  logic       clk,
  input  logic       resetn,
  // Request from the bus front end
  input  logic       req_valid,
  input  spi_reg_e   req_reg,
  input  logic       req_write,
  input  axil_data_t req_wdata,
  input  axil_strb_t req_wstrb,
  output logic       req_ready,
  output axil_data_t rdata,
  // SPI pins
  output logic       sclk,
  output logic       cen,
  output logic [3:0] sio_out,
  output logic [3:0] sio_oe,
  input  logic [3:0] sio_in
);

  spi_state_e state_q;
  logic       quad_q;       // Mode for the next transfer
  logic       xfer_quad_q;  // Mode of the transfer in progress
  spi_div_t   div_q;
  spi_div_t   div_eff;
  spi_div_t   tick_cnt;
  spi_byte_t  shift_q;
  spi_byte_t  shift_in;
  spi_byte_t  rx_q;
  logic [3:0] bits_left;
  logic [3:0] step;
  logic       busy;
  logic       tick;
  logic       lead_edge;
  logic       last_bit;
  logic       accept;
  logic       start;

  assign busy      = (state_q != IDLE);
  assign div_eff   = (div_q == '0) ? spi_div_t'(1) : div_q;  // Zero behaves as one
  assign tick      = (tick_cnt == div_eff - spi_div_t'(1));
  assign lead_edge = (sclk == `SPI_CPOL);   // Next toggle leaves the idle level
  assign step      = xfer_quad_q ? 4'd4 : 4'd1;
  assign last_bit  = (bits_left == step);
  assign shift_in  = xfer_quad_q ? {shift_q[3:0], sio_in} : {shift_q[6:0], sio_in[1]};

  // DATA must not overlap a running byte
  assign accept = req_valid && !req_ready && ((req_reg != DATA) || !busy);
  assign start  = accept && req_write && (req_reg == DATA) && req_wstrb[0];

  // ==============================
  // Register file
  // ==============================
  always_ff @(posedge clk) begin
    if (!resetn) begin
      req_ready <= 1'b0;
      cen       <= 1'b1;
      quad_q    <= 1'b0;
      div_q     <= spi_div_t'(1);
    end else begin
      req_ready <= accept;  // One cycle pulse, the request drops right after
      if (accept && req_write && (req_reg == CTRL) && req_wstrb[0]) begin
        cen    <= !req_wdata[0];
        quad_q <= req_wdata[1];
      end
      if (accept && req_write && (req_reg == DIV)) begin
        for (int b = 0; b < `SPI_DIV_W / 8; b++) begin
          if (req_wstrb[b]) div_q[b*8 +: 8] <= req_wdata[b*8 +: 8];
        end
      end
    end
  end

  always_comb begin
    case (req_reg)
      CTRL:    rdata = {busy, 29'b0, quad_q, cen};
      DATA:    rdata = {24'b0, rx_q};
      DIV:     rdata = {{(32 - `SPI_DIV_W){1'b0}}, div_q};
      default: rdata = '0;
    endcase
  end

  // ==============================
  // Divider and shift engine
  // ==============================
  always_ff @(posedge clk) begin
    if (!resetn || (state_q == IDLE)) begin
      tick_cnt <= '0;
    end else begin
      tick_cnt <= tick ? '0 : tick_cnt + spi_div_t'(1);
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state_q     <= IDLE;
      sclk        <= `SPI_CPOL;
      sio_oe      <= 4'b0001;
      sio_out     <= 4'b0000;
      bits_left   <= 4'd0;
      xfer_quad_q <= 1'b0;
      rx_q        <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          if (start) begin
            // First bits go out before the first leading edge
            xfer_quad_q <= quad_q;
            sio_oe      <= quad_q ? 4'b1111 : 4'b0001;
            sio_out     <= quad_q ? req_wdata[7:4] : {3'b000, req_wdata[7]};
            bits_left   <= 4'd8;
            state_q     <= SHIFT;
          end
        end
        SHIFT: begin
          if (tick) begin
            sclk <= !sclk;
            if (lead_edge) begin
              bits_left <= bits_left - step;
              if (last_bit) state_q <= DONE;
            end else begin
              sio_out <= xfer_quad_q ? shift_q[7:4] : {3'b000, shift_q[7]};
            end
          end
        end
        DONE: begin
          // Final trailing edge returns sclk to idle and the byte is stored
          if (tick) begin
            sclk    <= `SPI_CPOL;
            sio_oe  <= 4'b0001;
            rx_q    <= shift_q;
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      shift_q <= req_wdata[7:0];
    end else if ((state_q == SHIFT) && tick && lead_edge) begin
      shift_q <= shift_in;  // Sample on the leading edge
    end
  end

  a_oe_stable: assert property (@(posedge clk) disable iff (!resetn)
    busy && $past(busy) |-> $stable(sio_oe));

  a_ready_pulse: assert property (@(posedge clk) disable iff (!resetn)
    req_ready |=> !req_ready);

endmodule

// ==== tests/spi_device_model.sv ====
/*
 * Behavioral SPI device for one channel with CPHA 0 and CPOL 0.
 * Samples on the rising sclk edge and drives on the falling edge.
 * It answers each byte with the byte it received before it, and 0 at first.
 * Quad mode is recognized by all four output enables being set.
 */
`timescale 1ns/1ps

module spi_device_model (
  input  logic        sclk,
  input  logic        cen,
  input  logic [3:0]  sio_out,
  input  logic [3:0]  sio_oe,
  output logic [3:0]  sio_in,
  output logic [7:0]  rx_last,
  output logic [31:0] byte_count
);

  logic [7:0] tx;
  logic [7:0] rx_sh;
  logic [7:0] nxt;
  logic [3:0] cnt;    // Bits sampled in the current byte
  logic [3:0] pos;    // Bits already driven out
  logic       done;
  logic       quad;

  assign quad   = (sio_oe == 4'b1111);
  assign sio_in = quad ? ((pos == 4'd0) ? tx[7:4] : tx[3:0])
                       : {2'b00, tx[3'd7 - pos[2:0]], 1'b0};

  initial begin
    tx         = 8'h00;
    rx_sh      = 8'h00;
    rx_last    = 8'h00;
    cnt        = 4'd0;
    pos        = 4'd0;
    done       = 1'b0;
    byte_count = 32'd0;
  end

  // A new selection starts at a byte boundary
  always @(negedge cen) begin
    cnt <= 4'd0;
    pos <= 4'd0;
  end

  always @(posedge sclk) begin
    if (!cen) begin
      nxt = quad ? {rx_sh[3:0], sio_out} : {rx_sh[6:0], sio_out[0]};
      if (cnt + (quad ? 4'd4 : 4'd1) == 4'd8) begin
        rx_last    <= nxt;
        byte_count <= byte_count + 32'd1;
        cnt        <= 4'd0;
        done       <= 1'b1;
      end else begin
        rx_sh <= nxt;
        cnt   <= cnt + (quad ? 4'd4 : 4'd1);
      end
    end
  end

  always @(negedge sclk) begin
    if (!cen) begin
      if (done) begin
        tx   <= rx_last;  // Echo on the next byte
        pos  <= 4'd0;
        done <= 1'b0;
      end else begin
        pos <= cnt;
      end
    end
  end

endmodule

// ==== tests/tb_spi_host.sv ====
/*
 * Testbench for the SPI host with one device model per channel.
 * Assumes SPI_CPOL is 0 and that DIV values in transfers stay below 4.
 */
`timescale 1ns/1ps
`include "spi_cfg.svh"

module tb_spi_host import axil_pkg::*, spi_pkg::*; ();

  localparam int N_CH    = `SPI_NUM_CH;
  localparam int N_REG   = 12;
  localparam int N_XFER  = 20;
  localparam int OP_MAX  = 16;                 // One bus access with the longest stall
  localparam int BYTE_MAX = 2 * 8 * 3 + 8;     // Single byte at DIV 3
  localparam int LIMIT   = (2 * N_CH + 4 * N_REG + 4 * N_CH + 10) * OP_MAX
                           + 2 * N_XFER * (6 * OP_MAX + 2 * BYTE_MAX) + 500;

  logic                  clk;
  logic                  resetn;
  logic                  s_awvalid;
  logic                  s_awready;
  logic                  s_wvalid;
  logic                  s_wready;
  axil_addr_t            s_awaddr;
  axil_addr_t            s_araddr;
  axil_data_t            s_wdata;
  axil_data_t            s_rdata;
  axil_strb_t            s_wstrb;
  logic                  s_bvalid;
  logic                  s_bready;
  logic                  s_arvalid;
  logic                  s_arready;
  logic                  s_rvalid;
  logic                  s_rready;
  axil_resp_e            s_bresp;
  axil_resp_e            s_rresp;
  logic [N_CH-1:0]       sclk;
  logic [N_CH-1:0]       cen;
  logic [N_CH-1:0][3:0]  sio_out;
  logic [N_CH-1:0][3:0]  sio_oe;
  logic [N_CH-1:0][3:0]  sio_in;
  logic [7:0]            dev_rx [N_CH];
  logic [31:0]           dev_count [N_CH];

  logic [31:0] seed;
  int          cycles = 0;
  logic [31:0] b_done;                // Device byte count when bvalid appeared
  logic        model_quad [N_CH];
  logic        model_cs [N_CH];
  spi_div_t    model_div [N_CH];
  spi_byte_t   model_prev [N_CH];     // Last byte sent on each channel
  time         rise_t [N_CH];
  logic        rise_seen [N_CH];

  spi_host_top dut0 (
    .clk(clk), .resetn(resetn),
    .s_awvalid(s_awvalid), .s_awready(s_awready), .s_awaddr(s_awaddr),
    .s_wvalid(s_wvalid), .s_wready(s_wready), .s_wdata(s_wdata), .s_wstrb(s_wstrb),
    .s_bvalid(s_bvalid), .s_bready(s_bready), .s_bresp(s_bresp),
    .s_arvalid(s_arvalid), .s_arready(s_arready), .s_araddr(s_araddr),
    .s_rvalid(s_rvalid), .s_rready(s_rready), .s_rdata(s_rdata), .s_rresp(s_rresp),
    .sclk(sclk), .cen(cen), .sio_out(sio_out), .sio_oe(sio_oe), .sio_in(sio_in)
  );

  // ==============================
  // Devices and pin monitors
  // ==============================
  for (genvar i = 0; i < N_CH; i++) begin : g_dev
    spi_device_model u_dev (
      .sclk(sclk[i]), .cen(cen[i]), .sio_out(sio_out[i]), .sio_oe(sio_oe[i]),
      .sio_in(sio_in[i]), .rx_last(dev_rx[i]), .byte_count(dev_count[i])
    );

    always @(posedge sclk[i]) begin
      rise_t[i]    = $time;
      rise_seen[i] = 1'b1;
      check_value("sio_oe", 32'(sio_oe[i]), model_quad[i] ? 32'hF : 32'h1);
    end

    // High phase of sclk spans max(DIV,1) clock periods
    always @(negedge sclk[i]) begin
      if (rise_seen[i]) begin
        check_value("sclk half period", 32'($time - rise_t[i]),
                    32'((model_div[i] == 0) ? 1 : model_div[i]) * 32'd40);
      end
    end
  end

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > LIMIT) begin
      $display("Run did not finish within %0d cycles", LIMIT);
      $display("TB FAILED");
      $fatal(1);
    end
  end

  // ==============================
  // Helpers
  // ==============================
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    seed = xorshift32(seed);
    return seed;
  endfunction

  function automatic axil_addr_t reg_addr(input int ch, input spi_reg_e r);
    return axil_addr_t'(ch * `SPI_CH_STRIDE + int'(r));
  endfunction

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
      $display("TB FAILED");
      $fatal(1);
    end
  endtask

  task automatic write_reg(input axil_addr_t addr, input axil_data_t data, input int stall,
                           output axil_resp_e resp, output int lat);
    int ch;
    ch = addr / `SPI_CH_STRIDE;
    @(posedge clk);
    #1;
    s_awvalid = 1'b1;
    s_awaddr  = addr;
    s_wvalid  = 1'b1;
    s_wdata   = data;
    s_wstrb   = 4'hF;
    do @(negedge clk); while (!s_awready);
    check_value("s_wready", 32'(s_wready), 32'h1);
    @(posedge clk);
    #1;
    s_awvalid = 1'b0;
    s_wvalid  = 1'b0;
    lat = 0;
    @(negedge clk);
    while (!s_bvalid) begin
      lat++;
      @(negedge clk);
    end
    resp = s_bresp;
    if (ch < N_CH) b_done = dev_count[ch];
    repeat (stall) begin
      @(negedge clk);
      check_value("s_bvalid", 32'(s_bvalid), 32'h1);
      check_value("s_bresp", 32'(s_bresp), 32'(resp));
    end
    @(posedge clk);
    #1 s_bready = 1'b1;
    @(posedge clk);
    #1 s_bready = 1'b0;
  endtask

  task automatic read_reg(input axil_addr_t addr, input int stall,
                          output axil_data_t data, output axil_resp_e resp, output int lat);
    @(posedge clk);
    #1;
    s_arvalid = 1'b1;
    s_araddr  = addr;
    do @(negedge clk); while (!s_arready);
    @(posedge clk);
    #1 s_arvalid = 1'b0;
    lat = 0;
    @(negedge clk);
    while (!s_rvalid) begin
      lat++;
      @(negedge clk);
    end
    data = s_rdata;
    resp = s_rresp;
    repeat (stall) begin
      @(negedge clk);
      check_value("s_rvalid", 32'(s_rvalid), 32'h1);
      check_value("s_rdata", s_rdata, data);
      check_value("s_rresp", 32'(s_rresp), 32'(resp));
    end
    @(posedge clk);
    #1 s_rready = 1'b1;
    @(posedge clk);
    #1 s_rready = 1'b0;
  endtask

  // Write that must be answered OKAY, with an optional latency check
  task automatic write_ok(input int ch, input spi_reg_e r, input axil_data_t data,
                          input int exp_lat);
    axil_resp_e resp;
    int         lat;
    write_reg(reg_addr(ch, r), data, next_rand() % 4, resp, lat);
    check_value("s_bresp", 32'(resp), 32'(OKAY));
    if (exp_lat > 0) check_value("bvalid latency", lat, exp_lat);
  endtask

  task automatic read_expect(input int ch, input spi_reg_e r, input axil_data_t exp,
                             input int exp_lat);
    axil_data_t data;
    axil_resp_e resp;
    int         lat;
    read_reg(reg_addr(ch, r), next_rand() % 4, data, resp, lat);
    check_value("s_rresp", 32'(resp), 32'(OKAY));
    check_value("s_rdata", data, exp);
    if (exp_lat > 0) check_value("rvalid latency", lat, exp_lat);
  endtask

  // ==============================
  // Test sequence
  // ==============================
  initial begin
    int         ch;
    int         c0;
    int         lat;
    logic [31:0] v;
    spi_byte_t  b1;
    spi_byte_t  b2;
    spi_byte_t  exp_rx;
    logic       pair;
    axil_data_t data;
    axil_resp_e resp;

    seed = 32'h2097_fbd6;
    resetn = 1'b0;
    s_awvalid = 1'b0;
    s_awaddr  = '0;
    s_wvalid  = 1'b0;
    s_wdata   = '0;
    s_wstrb   = '0;
    s_bready  = 1'b0;
    s_arvalid = 1'b0;
    s_araddr  = '0;
    s_rready  = 1'b0;
    for (int i = 0; i < N_CH; i++) begin
      model_quad[i] = 1'b0;
      model_cs[i]   = 1'b0;
      model_div[i]  = spi_div_t'(1);
      model_prev[i] = 8'h00;
      rise_seen[i]  = 1'b0;
    end
    repeat (3) @(posedge clk);
    #1 resetn = 1'b1;

    // Reset values at the pins and in the registers
    @(negedge clk);
    check_value("s_bvalid", 32'(s_bvalid), 32'h0);
    check_value("s_rvalid", 32'(s_rvalid), 32'h0);
    for (int i = 0; i < N_CH; i++) begin
      check_value("cen", 32'(cen[i]), 32'h1);
      check_value("sclk", 32'(sclk[i]), 32'(`SPI_CPOL));
      check_value("sio_oe", 32'(sio_oe[i]), 32'h1);
      read_expect(i, CTRL, 32'h1, 3);
      read_expect(i, DIV, 32'h1, 3);
    end

    // Register write and read back
    repeat (N_REG) begin
      ch = next_rand() % N_CH;
      v  = next_rand();
      write_ok(ch, CTRL, v, 2);
      model_cs[ch]   = v[0];
      model_quad[ch] = v[1];
      read_expect(ch, CTRL, {30'b0, model_quad[ch], !model_cs[ch]}, 3);
      check_value("cen", 32'(cen[ch]), 32'(!model_cs[ch]));
      v = next_rand();
      write_ok(ch, DIV, v, 2);
      model_div[ch] = v[`SPI_DIV_W-1:0];
      read_expect(ch, DIV, 32'(model_div[ch]), 3);
    end
    for (int i = 0; i < N_CH; i++) begin
      write_ok(i, CTRL, 32'h0, 2);
      model_cs[i]   = 1'b0;
      model_quad[i] = 1'b0;
    end

    // Byte transfers, single mode first and then quad
    for (int mode = 0; mode < 2; mode++) begin
      repeat (N_XFER) begin
        ch   = next_rand() % N_CH;
        pair = (next_rand() % 4) == 0;
        // Back to back pairs need a byte long enough to still be running
        if (pair) begin
          v = (mode == 0) ? 2 + next_rand() % 2 : 32'd3;
        end else begin
          v = next_rand() % 4;
        end
        write_ok(ch, DIV, v, 2);
        model_div[ch] = spi_div_t'(v);
        write_ok(ch, CTRL, {30'b0, mode[0], 1'b1}, 2);
        model_quad[ch] = mode[0];
        model_cs[ch]   = 1'b1;
        b1 = spi_byte_t'(next_rand());
        c0 = dev_count[ch];
        write_ok(ch, DATA, {24'b0, b1}, 2);
        exp_rx = model_prev[ch];
        model_prev[ch] = b1;
        if (pair) begin
          b2 = spi_byte_t'(next_rand());
          write_reg(reg_addr(ch, DATA), {24'b0, b2}, 0, resp, lat);
          check_value("s_bresp", 32'(resp), 32'(OKAY));
          if (lat <= 2) begin
            $display("DATA write on a busy channel was answered after %0d cycles", lat);
            $display("TB FAILED");
            $fatal(1);
          end
          check_value("bytes done at bvalid", b_done, c0 + 1);
          exp_rx = b1;
          model_prev[ch] = b2;
        end
        read_expect(ch, DATA, {24'b0, exp_rx}, 0);
        check_value("device rx", 32'(dev_rx[ch]), 32'(model_prev[ch]));
        read_expect(ch, CTRL, {30'b0, mode[0], 1'b0}, 3);
      end
      for (int i = 0; i < N_CH; i++) begin
        write_ok(i, CTRL, 32'h0, 2);
        model_cs[i] = 1'b0;
      end
    end

    // Addresses outside the channels and an unknown register offset
    read_reg(axil_addr_t'(N_CH * `SPI_CH_STRIDE), next_rand() % 4, data, resp, lat);
    check_value("s_rresp", 32'(resp), 32'(SLVERR));
    check_value("s_rdata", data, 32'h0);
    write_reg(axil_addr_t'(N_CH * `SPI_CH_STRIDE), 32'h1, next_rand() % 4, resp, lat);
    check_value("s_bresp", 32'(resp), 32'(SLVERR));
    read_reg(axil_addr_t'(8'h0C), next_rand() % 4, data, resp, lat);
    check_value("s_rresp", 32'(resp), 32'(SLVERR));
    check_value("s_rdata", data, 32'h0);

    $display("TB PASSED");
    $finish;
  end

endmodule
